/* files.f */
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_tracker.sv
verilog/icache_top.sv
verification/imem_model.sv
verification/icache_properties.sv
verification/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  # rtl, package first
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_tracker.sv
      - verilog/icache_top.sv

  # testbench, memory model and bound properties
  - target: test
    files:
      - verification/imem_model.sv
      - verification/icache_properties.sv
      - verification/icache_tb.sv

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  localparam int          RESET_CYCLES    = 16;
  localparam int          STEP_CYCLES     = 40;          // budget per fetch step
  localparam int          RANDOM_FETCHES  = 60;
  localparam int          FETCH_STEPS     = 13 + RANDOM_FETCHES;
  localparam int          PREFETCH_WAIT   = 60;          // idle cycles before prefetch checks
  localparam int          WATCHDOG_CYCLES = RESET_CYCLES + FETCH_STEPS * STEP_CYCLES
                                            + PREFETCH_WAIT;
  localparam logic [63:0] FIRST_ADDR      = 64'h0125;    // unaligned on purpose
  localparam logic [63:0] PF_BASE         = 64'h0800;
  localparam logic [63:0] CONFLICT_A      = 64'h2000;
  localparam logic [63:0] CONFLICT_B      = CONFLICT_A + icache_pkg::NUM_LINES * 8;  // same idx

  logic                  clock;
  logic                  reset;
  logic [63:0]           fetch_addr;
  logic [63:0]           fetch_data;
  logic                  fetch_valid;
  icache_pkg::mem_req_t  mem_req;
  icache_pkg::mem_resp_t mem_resp;

  integer      seed = 50;
  logic [63:0] exp_word;
  logic        prev_denied = 1'b0;
  logic [63:0] prev_addr = '0;
  int unsigned words_checked = 0;
  int unsigned denials = 0;

  icache_top icache_top_i (
    .i_clock       (clock),
    .i_reset       (reset),
    .i_fetch_addr  (fetch_addr),
    .i_mem_resp    (mem_resp),
    .o_mem_req     (mem_req),
    .o_fetch_data  (fetch_data),
    .o_fetch_valid (fetch_valid)
  );

  imem_model imem_model_i (
    .i_clock    (clock),
    .i_reset    (reset),
    .i_mem_req  (mem_req),
    .o_mem_resp (mem_resp)
  );

  // memory image, every field depends on the whole line address
  function automatic logic [63:0] mem_word(input logic [icache_pkg::LINE_BITS-1:0] line);
    logic [15:0] l;
    l = line;
    return {l ^ 16'hC0DE, ~l, l + 16'h1234, {l[7:0], l[15:8]}};
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_mismatch(input string sig, input logic [63:0] got,
                                input logic [63:0] expected);
    abort_run($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, sig, got, expected));
  endtask

  // called at a rising edge, returns at the edge where the word is valid
  task automatic fetch_until_valid(input logic [63:0] addr, input bit expect_miss);
    fetch_addr <= addr;
    @(posedge clock);
    if (expect_miss) begin
      assert (!fetch_valid)
        else abort_run($sformatf("address %h hit where a miss was expected", addr));
    end
    while (!fetch_valid) begin
      @(posedge clock);
    end
  endtask

  task automatic fetch_expect_hit(input logic [63:0] addr);
    fetch_addr <= addr;
    @(posedge clock);
    assert (fetch_valid)
      else abort_run($sformatf("address %h not valid in its first fetch cycle", addr));
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // data check on every valid cycle
  always @(posedge clock) begin
    if (!reset && fetch_valid) begin
      exp_word = mem_word(fetch_addr[icache_pkg::ADDR_BITS-1:3]);
      assert (fetch_data == exp_word)
        else value_mismatch("o_fetch_data", fetch_data, exp_word);
      words_checked <= words_checked + 1;
    end
  end

  // bus rules seen at the ports
  always @(posedge clock) begin
    if (reset) begin
      assert (mem_req.cmd == icache_pkg::BUS_NONE)
        else value_mismatch("o_mem_req.cmd", 64'(mem_req.cmd), 64'(icache_pkg::BUS_NONE));
      prev_denied <= 1'b0;
    end else begin
      if (prev_denied) begin
        assert (mem_req.cmd == icache_pkg::BUS_LOAD)
          else abort_run("denied load was not issued again in the next cycle");
        assert (mem_req.addr == prev_addr)
          else value_mismatch("o_mem_req.addr", mem_req.addr, prev_addr);
      end
      prev_denied <= (mem_req.cmd == icache_pkg::BUS_LOAD) && (mem_resp.response == '0);
      prev_addr   <= mem_req.addr;
      if ((mem_req.cmd == icache_pkg::BUS_LOAD) && (mem_resp.response == '0)) begin
        denials <= denials + 1;
      end
    end
  end

  // bound bus assertions, stop at the first one that fires
  always @(posedge clock) begin
    if (icache_top_i.icache_properties_i.fail_count != 0) begin
      abort_run("bus protocol assertion failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    abort_run("watchdog expired before all fetches completed");
  end

  initial begin
    logic [63:0] addr;
    reset      = 1'b1;
    fetch_addr = FIRST_ADDR;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    // first cycle out of reset, empty cache
    @(posedge clock);
    assert (!fetch_valid) else abort_run("first fetch after reset hit in an empty cache");
    assert (mem_req.cmd == icache_pkg::BUS_LOAD)
      else abort_run("first miss after reset issued no load");
    assert (mem_req.addr == {FIRST_ADDR[63:3], 3'b000})
      else value_mismatch("o_mem_req.addr", mem_req.addr, {FIRST_ADDR[63:3], 3'b000});
    while (!fetch_valid) begin
      @(posedge clock);
    end
    fetch_expect_hit(FIRST_ADDR);                        // now a plain hit

    // sequential prefetch from a fresh line
    fetch_until_valid(PF_BASE, 1'b1);
    repeat (PREFETCH_WAIT) @(posedge clock);
    for (int k = 1; k < 8; k++) begin
      fetch_expect_hit(PF_BASE + k * 8);
    end

    // same index, other tag, then back
    fetch_until_valid(CONFLICT_A, 1'b1);
    fetch_until_valid(CONFLICT_B, 1'b1);
    fetch_until_valid(CONFLICT_A, 1'b1);

    for (int n = 0; n < RANDOM_FETCHES; n++) begin
      addr = {48'h0, 16'($random(seed))};
      fetch_until_valid(addr, 1'b0);
    end

    $display("%0d words checked, %0d denied loads", words_checked, denials);
    if (denials == 0) begin
      abort_run("no load was denied, so the retry path was never exercised");
    end else if (icache_top_i.icache_properties_i.fail_count != 0) begin
      abort_run("bus protocol assertion failed during the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verification/icache_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
  input logic                  i_clock,
  input logic                  i_reset,
  input icache_pkg::mem_req_t  i_mem_req,
  input icache_pkg::mem_resp_t i_mem_resp
);

  int fail_count = 0;                                    // failures so far

  // bus stays quiet in reset
  reset_quiet: assert property (@(posedge i_clock)
    i_reset |-> (i_mem_req.cmd == icache_pkg::BUS_NONE))
    else begin
      fail_count = fail_count + 1;
      $error("load issued while in reset");
    end

  // denied load goes out again, same address, next cycle
  deny_retry: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_mem_req.cmd == icache_pkg::BUS_LOAD && i_mem_resp.response == '0)
    |=> (i_mem_req.cmd == icache_pkg::BUS_LOAD && i_mem_req.addr == $past(i_mem_req.addr)))
    else begin
      fail_count = fail_count + 1;
      $error("denied load not repeated with the same address");
    end

  // a load carries a known word address
  addr_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_mem_req.cmd == icache_pkg::BUS_LOAD)
    |-> (!$isunknown(i_mem_req.addr) && (i_mem_req.addr[2:0] == 3'b000)))
    else begin
      fail_count = fail_count + 1;
      $error("load address unknown or not word aligned");
    end

endmodule

bind icache_top icache_properties icache_properties_i (
  .i_clock    (i_clock),
  .i_reset    (i_reset),
  .i_mem_req  (o_mem_req),
  .i_mem_resp (i_mem_resp)
);

`default_nettype wire

/* verification/imem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_model (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  icache_pkg::mem_req_t  i_mem_req,
  output icache_pkg::mem_resp_t o_mem_resp
);

  integer seed = 50;                                     // denial and latency stream
  int unsigned cyc = 0;

  logic [icache_pkg::NUM_TXN-1:0]   busy;                // number handed out, not reusable yet
  logic [icache_pkg::NUM_TXN-1:0]   pending;             // accepted, data not sent yet
  logic [icache_pkg::LINE_BITS-1:0] line_of [icache_pkg::NUM_TXN];
  int unsigned                      due [icache_pkg::NUM_TXN];

  logic                             deny_roll = 1'b0;    // this cycle's denial decision
  logic [icache_pkg::TXN_BITS-1:0]  free_txn;
  logic [icache_pkg::TXN_BITS-1:0]  resp_num;
  logic [icache_pkg::TXN_BITS-1:0]  pick;
  logic [icache_pkg::TXN_BITS-1:0]  ret_tag = '0;
  logic [63:0]                      ret_data = '0;

  // lowest free nonzero number, 0 when all are out
  always_comb begin
    free_txn = '0;
    for (int t = icache_pkg::NUM_TXN - 1; t > 0; t--) begin
      if (!busy[t]) begin
        free_txn = t[icache_pkg::TXN_BITS-1:0];
      end
    end
  end

  // same-cycle answer, a full table also denies
  assign resp_num   = (i_mem_req.cmd == icache_pkg::BUS_LOAD && !deny_roll) ? free_txn : '0;
  assign o_mem_resp = {resp_num, ret_tag, ret_data};

  always @(posedge i_clock) begin
    if (i_reset) begin
      busy      <= '0;
      pending   <= '0;
      ret_tag   <= '0;
      ret_data  <= '0;
      deny_roll <= 1'b0;
      cyc       <= 0;
    end else begin
      cyc       <= cyc + 1;
      deny_roll <= (({$random(seed)} % 4) == 0);        // about one load in four
      // one return per cycle, the others wait
      pick = '0;
      for (int t = icache_pkg::NUM_TXN - 1; t > 0; t--) begin
        if (pending[t] && (cyc >= due[t])) begin
          pick = t[icache_pkg::TXN_BITS-1:0];
        end
      end
      ret_tag  <= pick;
      ret_data <= '0;
      if (pick != '0) begin
        pending[pick] <= 1'b0;
        ret_data      <= icache_tb.mem_word(line_of[pick]);
      end
      if (ret_tag != '0) begin
        busy[ret_tag] <= 1'b0;                           // free once its return cycle is over
      end
      if (resp_num != '0) begin
        busy[resp_num]    <= 1'b1;
        pending[resp_num] <= 1'b1;
        line_of[resp_num] <= i_mem_req.addr[icache_pkg::ADDR_BITS-1:3];
        due[resp_num]     <= cyc + 2 + ({$random(seed)} % 11);  // 2 to 12 cycles
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic [63:0]            i_fetch_addr,
  input  icache_pkg::mem_resp_t  i_mem_resp,
  output icache_pkg::mem_req_t   o_mem_req,
  output logic [63:0]            o_fetch_data,
  output logic                   o_fetch_valid
);

  logic                            fill;        // live tag came back
  logic [icache_pkg::IDX_BITS-1:0] fill_idx;
  logic [icache_pkg::IDX_BITS-1:0] alloc_idx;   // index of the load going out

  icache_ctrl icache_ctrl_i (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_fetch_addr   (i_fetch_addr),
    .i_mem_response (i_mem_resp.response),
    .i_fill         (fill),
    .i_fill_idx     (fill_idx),
    .i_fill_data    (i_mem_resp.data),
    .o_mem_req      (o_mem_req),
    .o_alloc_idx    (alloc_idx),
    .o_fetch_data   (o_fetch_data),
    .o_fetch_valid  (o_fetch_valid)
  );

  // response is nonzero only for an accepted load
  icache_tracker icache_tracker_i (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_alloc_txn (i_mem_resp.response),
    .i_alloc_idx (alloc_idx),
    .i_ret_tag   (i_mem_resp.tag),
    .o_fill      (fill),
    .o_fill_idx  (fill_idx)
  );

endmodule

`default_nettype wire

/* verilog/icache_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tracker (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic [icache_pkg::TXN_BITS-1:0]  i_alloc_txn,      // accepted txn number, 0 = none
  input  logic [icache_pkg::IDX_BITS-1:0]  i_alloc_idx,
  input  logic [icache_pkg::TXN_BITS-1:0]  i_ret_tag,        // returning txn, 0 = none
  output logic                             o_fill,
  output logic [icache_pkg::IDX_BITS-1:0]  o_fill_idx
);

  icache_pkg::txn_entry_t [icache_pkg::NUM_TXN-1:0] txn_table;
  icache_pkg::txn_entry_t [icache_pkg::NUM_TXN-1:0] next_txn_table;

  // entry 0 never goes valid, so tag 0 never fills
  assign o_fill     = txn_table[i_ret_tag].valid;
  assign o_fill_idx = txn_table[i_ret_tag].idx;

  always_comb begin
    next_txn_table = txn_table;
    if (o_fill) begin
      next_txn_table[i_ret_tag].valid = 1'b0;            // retire on return
    end
    // memory only hands out free numbers, a same-cycle reuse wins here
    if (i_alloc_txn != '0) begin
      next_txn_table[i_alloc_txn].valid = 1'b1;
      next_txn_table[i_alloc_txn].idx   = i_alloc_idx;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < icache_pkg::NUM_TXN; i++) begin
        txn_table[i].valid <= 1'b0;                      // idx left as is
      end
    end else begin
      txn_table <= next_txn_table;
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic [63:0]                      i_fetch_addr,     // byte addr from fetch
  input  logic [icache_pkg::TXN_BITS-1:0]  i_mem_response,   // same-cycle answer to a load
  input  logic                             i_fill,           // tracker says a live tag returned
  input  logic [icache_pkg::IDX_BITS-1:0]  i_fill_idx,
  input  logic [63:0]                      i_fill_data,
  output icache_pkg::mem_req_t             o_mem_req,
  output logic [icache_pkg::IDX_BITS-1:0]  o_alloc_idx,      // index for the tracker entry
  output logic [63:0]                      o_fetch_data,
  output logic                             o_fetch_valid
);

  icache_pkg::icache_line_t [icache_pkg::NUM_LINES-1:0] lines;
  icache_pkg::icache_line_t [icache_pkg::NUM_LINES-1:0] next_lines;

  // fetch side decode
  logic [icache_pkg::LINE_BITS-1:0] fetch_line;
  logic [icache_pkg::IDX_BITS-1:0]  fetch_idx;
  logic [icache_pkg::TAG_BITS-1:0]  fetch_tag;
  logic                             fetch_hit;
  logic                             fetch_miss;         // miss and nothing in flight there

  // request bookkeeping
  logic [icache_pkg::LINE_BITS-1:0] last_line;          // line addr of the last request
  logic                             last_denied;

  // prefetch candidate
  logic [icache_pkg::LINE_BITS-1:0] pf_line;
  logic [icache_pkg::IDX_BITS-1:0]  pf_idx;
  logic [icache_pkg::TAG_BITS-1:0]  pf_tag;
  logic [icache_pkg::LINE_BITS-1:0] pf_dist;            // distance ahead of the fetch line
  logic                             pf_hit;
  logic                             pf_in_window;
  logic                             pf_ok;

  // chosen request
  logic                             req_load;
  logic [icache_pkg::LINE_BITS-1:0] req_line;
  logic [icache_pkg::IDX_BITS-1:0]  req_idx;
  logic [icache_pkg::TAG_BITS-1:0]  req_tag;
  logic                             issue;
  logic                             accept;
  logic                             denied;

  // hit lookup, purely combinational
  assign fetch_line    = i_fetch_addr[icache_pkg::ADDR_BITS-1:3];
  assign fetch_idx     = fetch_line[icache_pkg::IDX_BITS-1:0];
  assign fetch_tag     = fetch_line[icache_pkg::LINE_BITS-1:icache_pkg::IDX_BITS];
  assign fetch_hit     = lines[fetch_idx].valid && (lines[fetch_idx].tag == fetch_tag);
  assign fetch_miss    = !fetch_hit && !lines[fetch_idx].requested;
  assign o_fetch_data  = lines[fetch_idx].data;
  assign o_fetch_valid = fetch_hit;

  // next sequential line after the last request
  assign pf_line      = last_line + 1'b1;
  assign pf_idx       = pf_line[icache_pkg::IDX_BITS-1:0];
  assign pf_tag       = pf_line[icache_pkg::LINE_BITS-1:icache_pkg::IDX_BITS];
  assign pf_hit       = lines[pf_idx].valid && (lines[pf_idx].tag == pf_tag);
  assign pf_dist      = pf_line - fetch_line;            // wraps, so lines behind fetch fall out
  assign pf_in_window = (pf_dist < icache_pkg::PREFETCH_LINES);
  assign pf_ok        = pf_in_window && !pf_hit && !lines[pf_idx].requested;

  // request select
  // a denied line goes out again first so the bus address holds until accepted
  always_comb begin
    req_load = 1'b1;
    req_line = last_line;
    if (last_denied) begin
      req_line = last_line;                              // retry
    end else if (fetch_miss) begin
      req_line = fetch_line;                             // demand miss
    end else if (pf_ok) begin
      req_line = pf_line;                                // prefetch
    end else begin
      req_load = 1'b0;
    end
  end

  assign req_idx = req_line[icache_pkg::IDX_BITS-1:0];
  assign req_tag = req_line[icache_pkg::LINE_BITS-1:icache_pkg::IDX_BITS];

  // no loads while in reset
  assign o_mem_req.cmd  = (req_load && !i_reset) ? icache_pkg::BUS_LOAD : icache_pkg::BUS_NONE;
  assign o_mem_req.addr = {{(64-icache_pkg::ADDR_BITS){1'b0}}, req_line, 3'b000};
  assign o_alloc_idx    = req_idx;

  assign issue  = (o_mem_req.cmd == icache_pkg::BUS_LOAD);
  assign accept = issue && (i_mem_response != '0);
  assign denied = issue && (i_mem_response == '0);

  // array next state
  always_comb begin
    next_lines = lines;
    if (i_fill) begin                                    // data back from memory
      next_lines[i_fill_idx].data      = i_fill_data;
      next_lines[i_fill_idx].valid     = 1'b1;
      next_lines[i_fill_idx].requested = 1'b0;
    end
    // a requested index is never picked again, so no clash with the fill above
    if (accept) begin
      next_lines[req_idx].valid     = 1'b0;              // evict old contents
      next_lines[req_idx].requested = 1'b1;
      next_lines[req_idx].tag       = req_tag;
    end
  end

  // tag and data keep their value through reset, only the flags clear
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < icache_pkg::NUM_LINES; i++) begin
        lines[i].valid     <= 1'b0;
        lines[i].requested <= 1'b0;
      end
    end else begin
      lines <= next_lines;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      last_line   <= '0;
      last_denied <= 1'b0;
    end else begin
      last_denied <= denied;
      if (issue) begin
        last_line <= req_line;
      end else if (pf_in_window) begin
        last_line <= pf_line;                            // step over lines present or in flight
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/icache_pkg.sv */
`default_nettype none

package icache_pkg;

  localparam int ADDR_BITS      = 16;                           // significant fetch addr bits
  localparam int NUM_LINES      = 32;                           // one 64b word per line
  localparam int IDX_BITS       = $clog2(NUM_LINES);
  localparam int TAG_BITS       = ADDR_BITS - IDX_BITS - 3;
  localparam int LINE_BITS      = ADDR_BITS - 3;                // line addr, byte offset dropped
  localparam int NUM_TXN        = 16;                           // txn 0 means none
  localparam int TXN_BITS       = 4;
  localparam int PREFETCH_LINES = 8;                            // window past the fetch line

  // memory bus command
  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_cmd_t;

  typedef struct packed {
    logic                valid;
    logic                requested;                             // load in flight for this index
    logic [TAG_BITS-1:0] tag;
    logic [63:0]         data;
  } icache_line_t;

  // one outstanding memory transaction
  typedef struct packed {
    logic                valid;
    logic [IDX_BITS-1:0] idx;                                   // cache index waiting for the data
  } txn_entry_t;

  typedef struct packed {
    bus_cmd_t    cmd;
    logic [63:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [TXN_BITS-1:0] response;                              // 0 = denied, else txn number
    logic [TXN_BITS-1:0] tag;                                   // 0 = no return this cycle
    logic [63:0]         data;
  } mem_resp_t;

endpackage

`default_nettype wire
